// File: rtl/trace_cfg.svh
`ifndef TRACE_CFG_SVH
`define TRACE_CFG_SVH

// Width of the PC and of register data.
`define TRACE_XLEN 64

// Record slots in the trace FIFO.
`define TRACE_FIFO_DEPTH 8

// Host bus address width.
`define TRACE_AXI_AW 8

// Custom opcode that ends a program run.
`define TRACE_TRAP_OPCODE 7'h6b

`endif

// File: rtl/commit_pkg.sv
`include "trace_cfg.svh"

package commit_pkg;

   typedef logic [`TRACE_XLEN-1:0] xlen_t;
   typedef logic [31:0]            insn_t;
   typedef logic [4:0]             reg_idx_t;
   typedef logic [7:0]             trap_code_t;
   typedef logic [31:0]            count_t;

   // Writeback port of the core, one retired instruction per valid cycle.
   typedef struct packed {
      logic     valid;
      xlen_t    pc;
      insn_t    insn;
      reg_idx_t rd;
      logic     rf_we;
      xlen_t    rd_dat;
   } wb_event_t;

   // One stored commit.
   typedef struct packed {
      xlen_t    pc;
      insn_t    insn;
      logic     wen;
      reg_idx_t wdest;
      xlen_t    wdata;
   } commit_rec_t;

   typedef struct packed {
      logic       trap_seen;
      trap_code_t trap_code;
      logic       overflow;
      count_t     cycle_cnt;
      count_t     instr_cnt;
   } trace_stat_t;

endpackage

// File: rtl/trace_bus_pkg.sv
`include "trace_cfg.svh"

package trace_bus_pkg;

   typedef logic [31:0]              axil_word_t;
   typedef logic [`TRACE_AXI_AW-1:0] axil_addr_t;
   typedef logic [3:0]               axil_strb_t;
   typedef logic [1:0]               axil_resp_t;

   localparam axil_resp_t RESP_OKAY = 2'b00;

   typedef struct packed {
      axil_addr_t addr;
      logic       valid;
   } axil_aw_t;

   typedef struct packed {
      axil_word_t data;
      axil_strb_t strb;
      logic       valid;
   } axil_w_t;

   typedef struct packed {
      axil_resp_t resp;
      logic       valid;
   } axil_b_t;

   typedef struct packed {
      axil_addr_t addr;
      logic       valid;
   } axil_ar_t;

   typedef struct packed {
      axil_word_t data;
      axil_resp_t resp;
      logic       valid;
   } axil_r_t;

   // Register map.
   localparam axil_addr_t REG_STATUS   = 'h00;
   localparam axil_addr_t REG_PC_LO    = 'h04;
   localparam axil_addr_t REG_PC_HI    = 'h08;
   localparam axil_addr_t REG_INSN     = 'h0C;
   localparam axil_addr_t REG_WDATA_LO = 'h10;
   localparam axil_addr_t REG_WDATA_HI = 'h14;
   localparam axil_addr_t REG_DEST     = 'h18;
   localparam axil_addr_t REG_CTRL     = 'h1C;
   localparam axil_addr_t REG_CYCLE    = 'h20;
   localparam axil_addr_t REG_INSTR    = 'h24;

   // Bit positions in REG_STATUS and REG_CTRL.
   localparam int STAT_NOT_EMPTY_BIT = 0;
   localparam int STAT_TRAP_BIT      = 1;
   localparam int STAT_OVERFLOW_BIT  = 2;
   localparam int CTRL_POP_BIT       = 0;
   localparam int CTRL_CLEAR_BIT     = 1;

endpackage

// File: rtl/commit_capture.sv
`timescale 1ns/10ps
`include "trace_cfg.svh"

module commit_capture
(
   input  logic                    i_clock,
   input  logic                    i_rst,
   input  commit_pkg::wb_event_t   i_wb,
   input  logic                    i_clear,
   input  logic                    i_full,
   output logic                    o_push,
   output commit_pkg::commit_rec_t o_rec,
   output commit_pkg::trace_stat_t o_stat
);
   import commit_pkg::*;

   localparam reg_idx_t A0_IDX = 5'd10;

   xlen_t      a0_shadow;
   logic       trap_seen;
   trap_code_t trap_code;
   logic       overflow;
   count_t     cycle_cnt;
   count_t     instr_cnt;
   logic       take;
   logic       is_trap;
   logic       a0_write;

   // Capture halts once a trap has been seen.
   assign take     = i_wb.valid & ~trap_seen;
   assign is_trap  = (i_wb.insn[6:0] == `TRACE_TRAP_OPCODE);
   assign a0_write = i_wb.valid & i_wb.rf_we & (i_wb.rd == A0_IDX);

   // Record payload, loaded only for stored events.
   always_ff @(posedge i_clock)
   begin
      if (take)
      begin
         o_rec.pc    <= i_wb.pc;
         o_rec.insn  <= i_wb.insn;
         o_rec.wen   <= i_wb.rf_we & (|i_wb.rd);
         o_rec.wdest <= i_wb.rd;
         o_rec.wdata <= i_wb.rd_dat;
      end
   end

   always_ff @(posedge i_clock)
   begin
      if (i_rst)
      begin
         o_push    <= 1'b0;
         a0_shadow <= '0;
         trap_seen <= 1'b0;
         trap_code <= '0;
         overflow  <= 1'b0;
         cycle_cnt <= '0;
         instr_cnt <= '0;
      end
      else
      begin
         o_push    <= take;
         cycle_cnt <= cycle_cnt + 1'b1;

         if (take)
            instr_cnt <= instr_cnt + 1'b1;

         if (a0_write)
            a0_shadow <= i_wb.rd_dat;

         if (i_clear)
         begin
            trap_seen <= 1'b0;
            overflow  <= 1'b0;
         end

         // Trap code is a0 as it stood before the trap instruction.
         if (take && is_trap)
         begin
            trap_seen <= 1'b1;
            trap_code <= a0_shadow[7:0];
         end

         // FIFO drops this record.
         if (o_push && i_full)
            overflow <= 1'b1;
      end
   end

   always_comb
   begin
      o_stat.trap_seen = trap_seen;
      o_stat.trap_code = trap_code;
      o_stat.overflow  = overflow;
      o_stat.cycle_cnt = cycle_cnt;
      o_stat.instr_cnt = instr_cnt;
   end

endmodule

// File: rtl/commit_fifo.sv
`timescale 1ns/10ps
`include "trace_cfg.svh"

module commit_fifo
(
   input  logic                    i_clock,
   input  logic                    i_rst,
   input  logic                    i_push,
   input  commit_pkg::commit_rec_t i_rec,
   input  logic                    i_pop,
   output commit_pkg::commit_rec_t o_head,
   output logic                    o_empty,
   output logic                    o_full
);
   import commit_pkg::*;

   localparam int DEPTH = `TRACE_FIFO_DEPTH;
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   commit_rec_t      mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             wr_en;
   logic             rd_en;

   // Wraps at DEPTH, so non power of two depths work too.
   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(DEPTH - 1))
         return '0;
      return ptr + 1'b1;
   endfunction

   // A full FIFO still takes a push when the head leaves in the same cycle.
   assign wr_en = i_push & (~o_full | i_pop);
   assign rd_en = i_pop & ~o_empty;

   assign o_empty = (count == '0);
   assign o_full  = (count == CNT_W'(DEPTH));
   assign o_head  = mem[rd_ptr];

   always_ff @(posedge i_clock)
   begin
      if (wr_en)
         mem[wr_ptr] <= i_rec;
   end

   always_ff @(posedge i_clock)
   begin
      if (i_rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= ptr_next(wr_ptr);
         if (rd_en)
            rd_ptr <= ptr_next(rd_ptr);

         case ({wr_en, rd_en})
            2'b10: count <= count + 1'b1;
            2'b01: count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// File: rtl/trace_axil_port.sv
`timescale 1ns/10ps
`include "trace_cfg.svh"

module trace_axil_port
(
   input  logic                    i_clock,
   input  logic                    i_rst,
   input  trace_bus_pkg::axil_aw_t i_aw,
   output logic                    o_awready,
   input  trace_bus_pkg::axil_w_t  i_w,
   output logic                    o_wready,
   output trace_bus_pkg::axil_b_t  o_b,
   input  logic                    i_bready,
   input  trace_bus_pkg::axil_ar_t i_ar,
   output logic                    o_arready,
   output trace_bus_pkg::axil_r_t  o_r,
   input  logic                    i_rready,
   input  commit_pkg::commit_rec_t i_head,
   input  logic                    i_empty,
   input  commit_pkg::trace_stat_t i_stat,
   output logic                    o_pop,
   output logic                    o_clear
);
   import trace_bus_pkg::*;

   typedef enum logic {WR_IDLE, WR_RESP} wr_state_t;
   typedef enum logic {RD_IDLE, RD_RESP} rd_state_t;

   wr_state_t  wr_state;
   rd_state_t  rd_state;
   logic       wr_accept;
   logic       rd_accept;
   logic       ctrl_hit;
   axil_word_t rd_word;
   axil_word_t rd_data;

   // Address and data are taken together, one write in flight.
   assign wr_accept = (wr_state == WR_IDLE) & i_aw.valid & i_w.valid;
   assign rd_accept = (rd_state == RD_IDLE) & i_ar.valid;

   assign o_awready = wr_accept;
   assign o_wready  = wr_accept;
   assign o_arready = rd_accept;

   // Commands act on the accepting edge.
   assign ctrl_hit = wr_accept & (i_aw.addr == REG_CTRL) & i_w.strb[0];
   assign o_pop    = ctrl_hit & i_w.data[CTRL_POP_BIT] & ~i_empty;
   assign o_clear  = ctrl_hit & i_w.data[CTRL_CLEAR_BIT];

   always_ff @(posedge i_clock)
   begin
      if (i_rst)
         wr_state <= WR_IDLE;
      else
      begin
         case (wr_state)
            WR_IDLE:
               if (wr_accept)
                  wr_state <= WR_RESP;
            WR_RESP:
               if (i_bready)
                  wr_state <= WR_IDLE;
            default:
               wr_state <= WR_IDLE;
         endcase
      end
   end

   // Register decode, 64-bit fields split into low and high words.
   always_comb
   begin
      rd_word = '0;
      case (i_ar.addr)
         REG_STATUS:
         begin
            rd_word[STAT_NOT_EMPTY_BIT] = ~i_empty;
            rd_word[STAT_TRAP_BIT]      = i_stat.trap_seen;
            rd_word[STAT_OVERFLOW_BIT]  = i_stat.overflow;
            rd_word[15:8]               = i_stat.trap_code;
         end
         REG_PC_LO:    rd_word = i_head.pc[31:0];
         REG_PC_HI:    rd_word = i_head.pc[`TRACE_XLEN-1:32];
         REG_INSN:     rd_word = i_head.insn;
         REG_WDATA_LO: rd_word = i_head.wdata[31:0];
         REG_WDATA_HI: rd_word = i_head.wdata[`TRACE_XLEN-1:32];
         REG_DEST:
         begin
            rd_word[5]   = i_head.wen;
            rd_word[4:0] = i_head.wdest;
         end
         REG_CYCLE:    rd_word = i_stat.cycle_cnt;
         REG_INSTR:    rd_word = i_stat.instr_cnt;
         default:      rd_word = '0;
      endcase
   end

   // Data sampled at acceptance and held until the host takes it.
   always_ff @(posedge i_clock)
   begin
      if (rd_accept)
         rd_data <= rd_word;
   end

   always_ff @(posedge i_clock)
   begin
      if (i_rst)
         rd_state <= RD_IDLE;
      else
      begin
         case (rd_state)
            RD_IDLE:
               if (rd_accept)
                  rd_state <= RD_RESP;
            RD_RESP:
               if (i_rready)
                  rd_state <= RD_IDLE;
            default:
               rd_state <= RD_IDLE;
         endcase
      end
   end

   always_comb
   begin
      o_b.resp  = RESP_OKAY;
      o_b.valid = (wr_state == WR_RESP);
      o_r.data  = rd_data;
      o_r.resp  = RESP_OKAY;
      o_r.valid = (rd_state == RD_RESP);
   end

endmodule

// File: rtl/commit_trace_top.sv
`timescale 1ns/10ps

module commit_trace_top
(
   input  logic                    i_clock,
   input  logic                    i_rst,
   input  commit_pkg::wb_event_t   i_wb,
   input  trace_bus_pkg::axil_aw_t i_aw,
   output logic                    o_awready,
   input  trace_bus_pkg::axil_w_t  i_w,
   output logic                    o_wready,
   output trace_bus_pkg::axil_b_t  o_b,
   input  logic                    i_bready,
   input  trace_bus_pkg::axil_ar_t i_ar,
   output logic                    o_arready,
   output trace_bus_pkg::axil_r_t  o_r,
   input  logic                    i_rready
);
   import commit_pkg::*;

   logic        push;
   logic        pop;
   logic        clear;
   logic        empty;
   logic        full;
   commit_rec_t rec;
   commit_rec_t head;
   trace_stat_t stat;

   commit_capture u_commit_capture
      (
         .i_clock    (i_clock),
         .i_rst      (i_rst),
         .i_wb       (i_wb),
         .i_clear    (clear),
         .i_full     (full),
         .o_push     (push),
         .o_rec      (rec),
         .o_stat     (stat)
      );

   commit_fifo u_commit_fifo
      (
         .i_clock    (i_clock),
         .i_rst      (i_rst),
         .i_push     (push),
         .i_rec      (rec),
         .i_pop      (pop),
         .o_head     (head),
         .o_empty    (empty),
         .o_full     (full)
      );

   trace_axil_port u_trace_axil_port
      (
         .i_clock    (i_clock),
         .i_rst      (i_rst),
         .i_aw       (i_aw),
         .o_awready  (o_awready),
         .i_w        (i_w),
         .o_wready   (o_wready),
         .o_b        (o_b),
         .i_bready   (i_bready),
         .i_ar       (i_ar),
         .o_arready  (o_arready),
         .o_r        (o_r),
         .i_rready   (i_rready),
         .i_head     (head),
         .i_empty    (empty),
         .i_stat     (stat),
         .o_pop      (pop),
         .o_clear    (clear)
      );

endmodule

// File: bench/commit_trace_checker.sv
`timescale 1ns/10ps

module commit_trace_checker
(
   input logic                    i_clock,
   input logic                    i_rst,
   input trace_bus_pkg::axil_aw_t i_aw,
   input logic                    i_awready,
   input trace_bus_pkg::axil_w_t  i_w,
   input logic                    i_wready,
   input trace_bus_pkg::axil_b_t  i_b,
   input logic                    i_bready,
   input trace_bus_pkg::axil_ar_t i_ar,
   input logic                    i_arready,
   input trace_bus_pkg::axil_r_t  i_r,
   input logic                    i_rready,
   input logic                    i_push,
   input logic                    i_pop,
   input logic                    i_empty,
   input logic                    i_full
);

   // Host side requests hold until the slave accepts them.
   aw_hold: assert property (@(posedge i_clock) disable iff (i_rst)
      i_aw.valid && !i_awready |=> i_aw.valid && $stable(i_aw.addr))
      else $error("AW valid or address changed before acceptance");

   w_hold: assert property (@(posedge i_clock) disable iff (i_rst)
      i_w.valid && !i_wready |=> i_w.valid && $stable(i_w.data))
      else $error("W valid or data changed before acceptance");

   ar_hold: assert property (@(posedge i_clock) disable iff (i_rst)
      i_ar.valid && !i_arready |=> i_ar.valid && $stable(i_ar.addr))
      else $error("AR valid or address changed before acceptance");

   // Responses hold while the host stalls.
   b_hold: assert property (@(posedge i_clock) disable iff (i_rst)
      i_b.valid && !i_bready |=> i_b.valid)
      else $error("B valid dropped before bready");

   r_hold: assert property (@(posedge i_clock) disable iff (i_rst)
      i_r.valid && !i_rready |=> i_r.valid && $stable(i_r.data))
      else $error("R valid or data changed before rready");

   // An extra record in a full FIFO would push the count past full.
   full_push: assert property (@(posedge i_clock) disable iff (i_rst)
      i_push && i_full && !i_pop |=> i_full)
      else $error("FIFO took a push while full");

   flag_excl: assert property (@(posedge i_clock) disable iff (i_rst)
      !(i_empty && i_full))
      else $error("FIFO empty and full at once");

endmodule

bind commit_trace_top commit_trace_checker u_commit_trace_checker
(
   .i_clock   (i_clock),
   .i_rst     (i_rst),
   .i_aw      (i_aw),
   .i_awready (o_awready),
   .i_w       (i_w),
   .i_wready  (o_wready),
   .i_b       (o_b),
   .i_bready  (i_bready),
   .i_ar      (i_ar),
   .i_arready (o_arready),
   .i_r       (o_r),
   .i_rready  (i_rready),
   .i_push    (push),
   .i_pop     (pop),
   .i_empty   (empty),
   .i_full    (full)
);

// File: bench/commit_trace_tb.sv
`timescale 1ns/10ps
`include "trace_cfg.svh"

module commit_trace_tb;
   import commit_pkg::*;
   import trace_bus_pkg::*;

   localparam int DEPTH   = `TRACE_FIFO_DEPTH;
   localparam int TIMEOUT = 50;

   logic        clock;
   logic        rst;
   wb_event_t   wb;
   axil_aw_t    aw;
   axil_w_t     w;
   axil_b_t     b;
   axil_ar_t    ar;
   axil_r_t     r;
   logic        awready;
   logic        wready;
   logic        arready;
   logic        bready;
   logic        rready;

   // Reference model of the recorder.
   commit_rec_t exp_q[$];
   xlen_t       m_a0;
   logic        m_trap;
   logic [7:0]  m_code;
   logic        m_ovf;
   int          m_instr;

   int          seed;
   int          checks;
   int          errors;
   int          timeouts;

   commit_trace_top u_commit_trace_top
      (
         .i_clock   (clock),
         .i_rst     (rst),
         .i_wb      (wb),
         .i_aw      (aw),
         .o_awready (awready),
         .i_w       (w),
         .o_wready  (wready),
         .o_b       (b),
         .i_bready  (bready),
         .i_ar      (ar),
         .o_arready (arready),
         .o_r       (r),
         .i_rready  (rready)
      );

   initial
   begin
      clock = 1'b0;
      forever #50 clock = ~clock;
   end

   task automatic check_word(input string name, input axil_word_t got, input axil_word_t want);
      checks++;
      if (got !== want)
      begin
         errors++;
         $display("** Error at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, want);
      end
   endtask

   task automatic note_timeout(input string what);
      timeouts++;
      $display("Timeout at %0t ns while waiting for %s.", $time, what);
   endtask

   task automatic axil_write(input axil_addr_t addr, input axil_word_t data);
      int n;
      @(posedge clock);
      aw.addr  <= addr;
      aw.valid <= 1'b1;
      w.data   <= data;
      w.strb   <= 4'hF;
      w.valid  <= 1'b1;
      bready   <= 1'b1;
      n = 0;
      @(negedge clock);
      while (!(awready && wready) && n < TIMEOUT)
      begin
         @(negedge clock);
         n++;
      end
      if (!(awready && wready))
         note_timeout("write address and data acceptance");
      @(posedge clock);
      aw.valid <= 1'b0;
      w.valid  <= 1'b0;
      n = 0;
      @(negedge clock);
      while (!b.valid && n < TIMEOUT)
      begin
         @(negedge clock);
         n++;
      end
      if (!b.valid)
         note_timeout("write response");
      check_word("b.resp", axil_word_t'(b.resp), 32'h0);
      @(posedge clock);
      bready <= 1'b0;
   endtask

   // hold is the number of cycles rready stays low once rvalid is up.
   task automatic axil_read(input axil_addr_t addr, input int hold, output axil_word_t data);
      int n;
      int i;
      @(posedge clock);
      ar.addr  <= addr;
      ar.valid <= 1'b1;
      rready   <= (hold == 0);
      n = 0;
      @(negedge clock);
      while (!arready && n < TIMEOUT)
      begin
         @(negedge clock);
         n++;
      end
      if (!arready)
         note_timeout("read address acceptance");
      @(posedge clock);
      ar.valid <= 1'b0;
      n = 0;
      @(negedge clock);
      while (!r.valid && n < TIMEOUT)
      begin
         @(negedge clock);
         n++;
      end
      if (!r.valid)
         note_timeout("read data");
      data = r.data;
      check_word("r.resp", axil_word_t'(r.resp), 32'h0);
      for (i = 0; i < hold; i++)
      begin
         @(negedge clock);
         checks++;
         if (!r.valid)
         begin
            errors++;
            $display("Read response dropped at %0t ns while rready was low.", $time);
         end
         check_word("r.data", r.data, data);
      end
      if (hold > 0)
      begin
         @(posedge clock);
         rready <= 1'b1;
         @(negedge clock);
         check_word("r.data", r.data, data);
      end
      @(posedge clock);
      rready <= 1'b0;
   endtask

   task automatic drive_commit(input xlen_t pc, input insn_t insn, input reg_idx_t rd,
                               input logic we, input xlen_t dat);
      commit_rec_t rec;
      rec.pc    = pc;
      rec.insn  = insn;
      rec.wen   = we && (rd != 5'd0);
      rec.wdest = rd;
      rec.wdata = dat;
      @(posedge clock);
      wb.valid  <= 1'b1;
      wb.pc     <= pc;
      wb.insn   <= insn;
      wb.rd     <= rd;
      wb.rf_we  <= we;
      wb.rd_dat <= dat;
      @(posedge clock);
      wb.valid  <= 1'b0;
      // A halted recorder neither stores nor counts.
      if (!m_trap)
      begin
         m_instr++;
         if (exp_q.size() < DEPTH)
            exp_q.push_back(rec);
         else
            m_ovf = 1'b1;
         if (insn[6:0] == `TRACE_TRAP_OPCODE)
         begin
            m_trap = 1'b1;
            m_code = m_a0[7:0];
         end
      end
      if (we && rd == 5'd10)
         m_a0 = dat;
   endtask

   task automatic drive_random_commit(input logic to_x0);
      xlen_t    pc;
      insn_t    insn;
      reg_idx_t rd;
      xlen_t    dat;
      pc   = {$random(seed), $random(seed)};
      insn = $random(seed);
      insn[6:0] = 7'h33;
      rd   = to_x0 ? 5'd0 : reg_idx_t'($random(seed));
      dat  = {$random(seed), $random(seed)};
      drive_commit(pc, insn, rd, 1'b1, dat);
   endtask

   task automatic check_status();
      axil_word_t got;
      axil_word_t want;
      want = {16'd0, m_code, 5'd0, m_ovf, m_trap, exp_q.size() != 0};
      axil_read(REG_STATUS, 0, got);
      check_word("STATUS", got, want);
   endtask

   task automatic check_instr();
      axil_word_t got;
      axil_read(REG_INSTR, 0, got);
      check_word("INSTR", got, axil_word_t'(m_instr));
   endtask

   task automatic pop_and_check();
      commit_rec_t want;
      axil_word_t  got;
      if (exp_q.size() == 0)
      begin
         errors++;
         $display("No expected record left to compare at %0t ns.", $time);
      end
      else
      begin
         want = exp_q.pop_front();
         axil_read(REG_PC_LO, 0, got);
         check_word("PC_LO", got, want.pc[31:0]);
         axil_read(REG_PC_HI, 0, got);
         check_word("PC_HI", got, want.pc[63:32]);
         axil_read(REG_INSN, 0, got);
         check_word("INSN", got, want.insn);
         axil_read(REG_WDATA_LO, 0, got);
         check_word("WDATA_LO", got, want.wdata[31:0]);
         axil_read(REG_WDATA_HI, 0, got);
         check_word("WDATA_HI", got, want.wdata[63:32]);
         axil_read(REG_DEST, 0, got);
         check_word("DEST", got, {26'd0, want.wen, want.wdest});
         axil_write(REG_CTRL, 32'h1);
      end
   endtask

   task automatic test_reset_state();
      axil_word_t got;
      check_status();
      axil_read(REG_CYCLE, 0, got);
      checks++;
      if (got == 0)
      begin
         errors++;
         $display("Cycle counter still zero after reset at %0t ns.", $time);
      end
      check_instr();
   endtask

   task automatic test_record_contents();
      int i;
      // The third commit writes x0 and must come back with wen low.
      for (i = 0; i < 5; i++)
         drive_random_commit(i == 2);
      check_status();
      while (exp_q.size() > 0)
         pop_and_check();
   endtask

   task automatic test_ordering();
      check_status();
      check_instr();
   endtask

   task automatic test_overflow();
      int i;
      for (i = 0; i < DEPTH + 3; i++)
         drive_random_commit(1'b0);
      check_status();
      check_instr();
      for (i = 0; i < DEPTH; i++)
         pop_and_check();
      check_status();
      axil_write(REG_CTRL, 32'h2);
      m_ovf = 1'b0;
      check_status();
   endtask

   task automatic test_trap();
      drive_commit(64'h8000_0100, 32'h00a0_0513, 5'd10, 1'b1, 64'h0000_1234_0000_3c5a);
      // The trap insn also writes a0, so the code must come from the older value.
      drive_commit(64'h8000_0104, 32'h0000_056b, 5'd10, 1'b1, 64'h0000_0000_0000_00c3);
      check_status();
      drive_random_commit(1'b0);
      check_instr();
      while (exp_q.size() > 0)
         pop_and_check();
      check_status();
      axil_write(REG_CTRL, 32'h2);
      m_trap = 1'b0;
      m_ovf  = 1'b0;
      drive_random_commit(1'b0);
      check_status();
      check_instr();
      pop_and_check();
   endtask

   task automatic test_backpressure();
      axil_word_t first;
      axil_word_t second;
      axil_read(REG_CYCLE, 6, first);
      axil_read(REG_CYCLE, 0, second);
      checks++;
      if (second <= first)
      begin
         errors++;
         $display("Cycle counter did not advance between reads at %0t ns.", $time);
      end
   endtask

   initial
   begin
      $timeformat(-9, 0, "", 0);
      seed     = 92;
      checks   = 0;
      errors   = 0;
      timeouts = 0;
      m_a0     = '0;
      m_trap   = 1'b0;
      m_code   = '0;
      m_ovf    = 1'b0;
      m_instr  = 0;
      rst      = 1'b1;
      wb       = '0;
      aw       = '0;
      w        = '0;
      ar       = '0;
      bready   = 1'b0;
      rready   = 1'b0;
      repeat (2) @(posedge clock);
      rst <= 1'b0;

      test_reset_state();
      test_record_contents();
      test_ordering();
      test_overflow();
      test_trap();
      test_backpressure();

      $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

// File: build.f
+incdir+rtl
rtl/commit_pkg.sv
rtl/trace_bus_pkg.sv
rtl/commit_capture.sv
rtl/commit_fifo.sv
rtl/trace_axil_port.sv
rtl/commit_trace_top.sv
bench/commit_trace_checker.sv
bench/commit_trace_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the commit trace testbench with Verilator.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module commit_trace_tb -f build.f \
   -o commit_trace_sim > build.log 2>&1 || { cat build.log; echo "Compile failed"; exit 1; }

./obj_dir/commit_trace_sim > "$LOG" 2>&1
cat "$LOG"

# An assertion stop leaves no pass line, so both searches are needed.
grep -q "TB FAILED" "$LOG" && { echo "Simulation failed"; exit 1; }
grep -q "TB PASSED" "$LOG" || { echo "Simulation did not complete"; exit 1; }
exit 0
